// File: image_pkg.sv
`default_nettype none

package image_pkg;

	typedef enum logic [3:0] {
		OP_LOAD       = 4'd0,
		OP_RIGHT      = 4'd1,
		OP_LEFT       = 4'd2,
		OP_UP         = 4'd3,
		OP_DOWN       = 4'd4,
		OP_DEPTH_DOWN = 4'd5,
		OP_DEPTH_UP   = 4'd6,
		OP_DISPLAY    = 4'd7,
		OP_CONV       = 4'd8,
		OP_MEDIAN     = 4'd9,  // no-op in this core
		OP_HAAR       = 4'd10  // no-op in this core
	} op_e;

	typedef enum logic [2:0] {
		PH_IDLE,
		PH_READY,
		PH_LOAD,
		PH_APPLY,
		PH_DISPLAY,
		PH_CONV,
		PH_DRAIN
	} phase_e;

	localparam int PIX_W   = 8;
	localparam int OUT_W   = 14;
	localparam int CONV_W  = 13;
	localparam int ACC_W   = 17;  // 32 ch x 16 x 255 fits
	localparam int IMG_DIM = 8;
	localparam int ORG_MAX = 6;
	localparam int COORD_W = 3;
	localparam int N_BANK  = 4;  // bank = column bits 1:0

endpackage

`default_nettype wire

// File: seq_if.sv
`timescale 1ns/10ps
`default_nettype none

interface seq_if #(parameter int N_CH = 32);
	localparam int STEP_W = $clog2(N_CH) + 6;
	localparam int DEP_W  = $clog2(N_CH) + 1;

	image_pkg::op_e                op;
	image_pkg::phase_e             phase;
	logic [STEP_W-1:0]             step;
	logic [image_pkg::COORD_W-1:0] org_row;
	logic [image_pkg::COORD_W-1:0] org_col;
	logic [DEP_W-1:0]              depth;
	logic [image_pkg::PIX_W-1:0]   in_byte;
	logic                          in_wr;   // in_byte is to be written this cycle

	modport seq  (output op, phase, step, org_row, org_col, depth, in_byte, in_wr);
	modport addr (input phase, step, org_row, org_col, in_byte, in_wr);
	modport conv (input phase, step, org_row, org_col, depth);
	modport out  (input op, phase, step, org_col);
endinterface

`default_nettype wire

// File: bank_if.sv
`timescale 1ns/10ps
`default_nettype none

interface bank_if #(parameter int N_CH = 32);
	localparam int BA_W = $clog2(N_CH) + 4;  // word address inside one bank

	logic [BA_W-1:0]               addr [image_pkg::N_BANK];
	logic [image_pkg::N_BANK-1:0]  wen_n;
	logic [image_pkg::PIX_W-1:0]   wdata;
	logic [image_pkg::PIX_W-1:0]   q    [image_pkg::N_BANK];

	modport gen (output addr, wen_n, wdata);
	modport mem (input addr, wen_n, wdata, output q);
	modport rd  (input q);
endinterface

`default_nettype wire

// File: op_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module op_sequencer #(
	parameter int N_CH = 32
) (
	input  logic                        i_clk,
	input  logic                        i_rst_n,
	input  logic                        i_op_valid,
	input  logic [3:0]                  i_op_mode,
	input  logic                        i_in_valid,
	input  logic [image_pkg::PIX_W-1:0] i_in_data,
	output logic                        o_op_ready,
	output logic                        o_in_ready,
	seq_if.seq                          seq
);
	localparam int CH_W   = $clog2(N_CH);
	localparam int STEP_W = CH_W + 6;
	localparam int DEP_W  = CH_W + 1;
	localparam logic [STEP_W-1:0] LOAD_LAST =
		STEP_W'(N_CH * image_pkg::IMG_DIM * image_pkg::IMG_DIM - 1);
	localparam logic [DEP_W-1:0] DEP_MAX = DEP_W'(N_CH);
	localparam logic [DEP_W-1:0] DEP_MIN = DEP_W'(N_CH / 4);
	localparam logic [image_pkg::COORD_W-1:0] ORG_LIM = image_pkg::COORD_W'(image_pkg::ORG_MAX);

	image_pkg::op_e                mode;
	image_pkg::op_e                op;
	image_pkg::phase_e             phase;
	image_pkg::phase_e             phase_nxt;
	logic [STEP_W-1:0]             step;
	logic [STEP_W-1:0]             quad;      // 4 x depth
	logic [STEP_W-1:0]             drain_last;
	logic [image_pkg::COORD_W-1:0] org_row;
	logic [image_pkg::COORD_W-1:0] org_col;
	logic [DEP_W-1:0]              depth;
	logic [image_pkg::PIX_W-1:0]   in_byte;
	logic                          in_wr;
	logic                          in_ready;
	logic                          op_ready;
	logic                          accept;
	logic                          last_accept;

	assign mode        = image_pkg::op_e'(i_op_mode);
	assign quad        = {depth, 2'b00};
	assign drain_last  = (op == image_pkg::OP_CONV) ? STEP_W'(4) : '0;  // 4 result beats
	assign accept      = i_in_valid && in_ready;
	assign last_accept = accept && (step + STEP_W'(in_wr) == LOAD_LAST);

	always_comb begin
		phase_nxt = phase;
		case (phase)
			image_pkg::PH_IDLE:    phase_nxt = image_pkg::PH_READY;
			image_pkg::PH_READY: begin
				if (i_op_valid) begin
					case (mode)
						image_pkg::OP_LOAD:    phase_nxt = image_pkg::PH_LOAD;
						image_pkg::OP_DISPLAY: phase_nxt = image_pkg::PH_DISPLAY;
						image_pkg::OP_CONV:    phase_nxt = image_pkg::PH_CONV;
						default:               phase_nxt = image_pkg::PH_APPLY;
					endcase
				end
			end
			image_pkg::PH_LOAD:    if (in_wr && step == LOAD_LAST) phase_nxt = image_pkg::PH_DRAIN;
			image_pkg::PH_APPLY:   phase_nxt = image_pkg::PH_READY;
			image_pkg::PH_DISPLAY: if (step == quad - 1'b1) phase_nxt = image_pkg::PH_DRAIN;
			image_pkg::PH_CONV:    if (step == quad + STEP_W'(2)) phase_nxt = image_pkg::PH_DRAIN;
			image_pkg::PH_DRAIN:   if (step == drain_last) phase_nxt = image_pkg::PH_READY;
			default:               phase_nxt = image_pkg::PH_IDLE;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			phase    <= image_pkg::PH_IDLE;
			op       <= image_pkg::OP_LOAD;
			step     <= '0;
			in_wr    <= 1'b0;
			in_ready <= 1'b0;
			op_ready <= 1'b0;
		end else begin
			phase    <= phase_nxt;
			op_ready <= (phase_nxt == image_pkg::PH_READY) && (phase != image_pkg::PH_READY);
			in_wr    <= accept;
			if (phase == image_pkg::PH_READY && i_op_valid)
				op <= mode;
			if (phase_nxt != phase)
				step <= '0;
			else if (phase == image_pkg::PH_LOAD ? in_wr :
					phase inside {image_pkg::PH_DISPLAY, image_pkg::PH_CONV, image_pkg::PH_DRAIN})
				step <= step + 1'b1;
			if (phase == image_pkg::PH_READY && phase_nxt == image_pkg::PH_LOAD)
				in_ready <= 1'b1;
			else if (last_accept)
				in_ready <= 1'b0;  // no byte past the last one
		end
	end

	always_ff @(posedge i_clk) begin
		in_byte <= i_in_data;
	end

	// saturating view updates
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			org_row <= '0;
			org_col <= '0;
			depth   <= DEP_MAX;
		end else if (phase == image_pkg::PH_APPLY) begin
			case (op)
				image_pkg::OP_RIGHT:      if (org_col != ORG_LIM) org_col <= org_col + 1'b1;
				image_pkg::OP_LEFT:       if (org_col != '0) org_col <= org_col - 1'b1;
				image_pkg::OP_DOWN:       if (org_row != ORG_LIM) org_row <= org_row + 1'b1;
				image_pkg::OP_UP:         if (org_row != '0) org_row <= org_row - 1'b1;
				image_pkg::OP_DEPTH_DOWN: if (depth != DEP_MIN) depth <= depth >> 1;
				image_pkg::OP_DEPTH_UP:   if (depth != DEP_MAX) depth <= depth << 1;
				default: ;
			endcase
		end
	end

	assign seq.op      = op;
	assign seq.phase   = phase;
	assign seq.step    = step;
	assign seq.org_row = org_row;
	assign seq.org_col = org_col;
	assign seq.depth   = depth;
	assign seq.in_byte = in_byte;
	assign seq.in_wr   = in_wr;

	assign o_op_ready = op_ready;
	assign o_in_ready = in_ready;

endmodule

`default_nettype wire

// File: bank_addr_gen.sv
`timescale 1ns/10ps
`default_nettype none

module bank_addr_gen #(
	parameter int N_CH = 32
) (
	seq_if.addr seq,
	bank_if.gen bank
);
	localparam int CH_W = $clog2(N_CH);
	localparam int BA_W = CH_W + 4;

	logic [CH_W-1:0]               ch;
	logic [image_pkg::COORD_W-1:0] row;
	logic [image_pkg::COORD_W-1:0] col;
	logic [image_pkg::COORD_W-1:0] crow;
	logic [image_pkg::COORD_W-1:0] ccol;

	assign ch  = seq.step[CH_W+1:2];  // 4 steps per channel
	assign row = seq.org_row + image_pkg::COORD_W'(seq.step[1]);
	assign col = seq.org_col + image_pkg::COORD_W'(seq.step[0]);
	assign crow = seq.org_row - 1'b1 + image_pkg::COORD_W'(seq.step[1:0]);  // wraps at edges

	assign bank.wdata = seq.in_byte;

	always_comb begin
		ccol = '0;
		for (int b = 0; b < image_pkg::N_BANK; b++) begin
			bank.addr[b]  = seq.step[BA_W+1:2];  // load: byte counter
			bank.wen_n[b] = !(seq.phase == image_pkg::PH_LOAD && seq.in_wr &&
				seq.step[1:0] == 2'(b));
		end
		case (seq.phase)
			image_pkg::PH_DISPLAY: begin
				for (int b = 0; b < image_pkg::N_BANK; b++)
					bank.addr[b] = {ch, row, col[2]};
			end
			image_pkg::PH_CONV: begin
				// four adjacent columns land in four different banks
				for (int j = 0; j < image_pkg::N_BANK; j++) begin
					ccol = seq.org_col - 1'b1 + image_pkg::COORD_W'(j);
					bank.addr[ccol[1:0]] = {ch, crow, ccol[2]};
				end
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: image_bank.sv
`timescale 1ns/10ps
`default_nettype none

module image_bank #(
	parameter int N_CH = 32
) (
	input  logic i_clk,
	bank_if.mem  bank
);
	localparam int DEPTH = N_CH * image_pkg::IMG_DIM * image_pkg::IMG_DIM / image_pkg::N_BANK;

	for (genvar b = 0; b < image_pkg::N_BANK; b++) begin : g_bank
		logic [image_pkg::PIX_W-1:0] mem [DEPTH];

		always_ff @(posedge i_clk) begin
			if (!bank.wen_n[b])
				mem[bank.addr[b]] <= bank.wdata;
			bank.q[b] <= mem[bank.addr[b]];  // one cycle read
		end
	end

endmodule

`default_nettype wire

// File: conv_engine.sv
`timescale 1ns/10ps
`default_nettype none

module conv_engine #(
	parameter int N_CH = 32
) (
	input  logic                         i_clk,
	input  logic                         i_rst_n,
	seq_if.conv                          seq,
	bank_if.rd                           bank,
	output logic                         o_res_valid,
	output logic [image_pkg::CONV_W-1:0] o_res [4]
);
	localparam int STEP_W = $clog2(N_CH) + 6;
	localparam int ACC_W  = image_pkg::ACC_W;
	localparam logic [image_pkg::COORD_W-1:0] ORG_LIM = image_pkg::COORD_W'(image_pkg::ORG_MAX);

	logic [STEP_W-1:0]           rd_end;  // number of read steps
	logic                        g_vld;
	logic [1:0]                  g_row;
	logic                        acc_go;
	logic                        res_go;
	logic [3:0]                  row_ok;
	logic [3:0]                  col_ok;
	logic [1:0]                  wsel;
	logic [image_pkg::PIX_W-1:0] rowpix [4];
	logic [image_pkg::PIX_W-1:0] win    [4][4];
	logic [ACC_W-1:0]            psum   [4];
	logic [ACC_W-1:0]            acc    [4];

	assign rd_end = {seq.depth, 2'b00};
	assign res_go = (seq.phase == image_pkg::PH_CONV) && (seq.step == rd_end + STEP_W'(2));

	// zero padding, outer rows and columns only
	assign row_ok = {seq.org_row != ORG_LIM, 2'b11, seq.org_row != '0};
	assign col_ok = {seq.org_col != ORG_LIM, 2'b11, seq.org_col != '0};

	always_comb begin
		wsel = '0;
		for (int j = 0; j < 4; j++) begin
			wsel      = seq.org_col[1:0] - 2'd1 + 2'(j);
			rowpix[j] = (row_ok[g_row] && col_ok[j]) ? bank.q[wsel] : '0;
		end
	end

	// 1-2-1 / 2-4-2 / 1-2-1 around each of the four centres
	always_comb begin
		for (int o = 0; o < 4; o++) begin
			psum[o] = '0;
			for (int dr = 0; dr < 3; dr++) begin
				for (int dc = 0; dc < 3; dc++) begin
					psum[o] = psum[o] + (ACC_W'(win[o/2+dr][o%2+dc]) <<
						(int'(dr == 1) + int'(dc == 1)));
				end
			end
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			g_vld       <= 1'b0;
			g_row       <= '0;
			acc_go      <= 1'b0;
			o_res_valid <= 1'b0;
			for (int o = 0; o < 4; o++)
				acc[o] <= '0;
		end else begin
			g_vld       <= (seq.phase == image_pkg::PH_CONV) && (seq.step < rd_end);
			g_row       <= seq.step[1:0];
			acc_go      <= g_vld && (g_row == 2'd3);  // window of one channel complete
			o_res_valid <= res_go;
			for (int o = 0; o < 4; o++) begin
				if (seq.phase != image_pkg::PH_CONV)
					acc[o] <= '0;
				else if (acc_go)
					acc[o] <= acc[o] + psum[o];
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (g_vld)
			win[g_row] <= rowpix;
		if (res_go) begin
			for (int o = 0; o < 4; o++)
				o_res[o] <= acc[o][ACC_W-1:4] + image_pkg::CONV_W'(acc[o][3]);  // /16, half up
		end
	end

endmodule

`default_nettype wire

// File: pixel_output.sv
`timescale 1ns/10ps
`default_nettype none

module pixel_output (
	input  logic                         i_clk,
	input  logic                         i_rst_n,
	seq_if.out                           seq,
	bank_if.rd                           bank,
	input  logic                         i_res_valid,
	input  logic [image_pkg::CONV_W-1:0] i_res [4],
	output logic                         o_out_valid,
	output logic [image_pkg::OUT_W-1:0]  o_out_data
);
	logic                         disp_vld;
	logic [1:0]                   disp_bank;  // bank of last cycle's pixel
	logic [3:0]                   beat_vld;
	logic [image_pkg::CONV_W-1:0] res_q [4];
	logic                         is_conv;

	assign is_conv = (seq.op == image_pkg::OP_CONV);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			disp_vld  <= 1'b0;
			disp_bank <= '0;
			beat_vld  <= '0;
		end else begin
			disp_vld  <= (seq.phase == image_pkg::PH_DISPLAY);
			disp_bank <= seq.org_col[1:0] + 2'(seq.step[0]);
			if (i_res_valid)
				beat_vld <= 4'b1111;
			else
				beat_vld <= beat_vld >> 1;
		end
	end

	// result shift register, head is the current beat
	always_ff @(posedge i_clk) begin
		if (i_res_valid) begin
			res_q <= i_res;
		end else if (beat_vld[0]) begin
			for (int k = 0; k < 3; k++)
				res_q[k] <= res_q[k+1];
		end
	end

	assign o_out_valid = is_conv ? beat_vld[0] : disp_vld;
	assign o_out_data  = is_conv ? image_pkg::OUT_W'(res_q[0]) :
		image_pkg::OUT_W'(bank.q[disp_bank]);

endmodule

`default_nettype wire

// File: image_core.sv
`timescale 1ns/10ps
`default_nettype none

module image_core #(
	parameter int N_CH = 32  // power of two, 8 or more
) (
	input  logic                        i_clk,
	input  logic                        i_rst_n,
	input  logic                        i_op_valid,
	input  logic [3:0]                  i_op_mode,
	output logic                        o_op_ready,
	input  logic                        i_in_valid,
	input  logic [image_pkg::PIX_W-1:0] i_in_data,
	output logic                        o_in_ready,
	output logic                        o_out_valid,
	output logic [image_pkg::OUT_W-1:0] o_out_data
);
	logic                         res_valid;
	logic [image_pkg::CONV_W-1:0] res [4];

	seq_if  #(.N_CH(N_CH)) u_seq ();
	bank_if #(.N_CH(N_CH)) u_bank ();

	op_sequencer #(.N_CH(N_CH)) u_op_sequencer (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_op_valid (i_op_valid),
		.i_op_mode  (i_op_mode),
		.i_in_valid (i_in_valid),
		.i_in_data  (i_in_data),
		.o_op_ready (o_op_ready),
		.o_in_ready (o_in_ready),
		.seq        (u_seq.seq)
	);

	bank_addr_gen #(.N_CH(N_CH)) u_bank_addr_gen (
		.seq  (u_seq.addr),
		.bank (u_bank.gen)
	);

	image_bank #(.N_CH(N_CH)) u_image_bank (
		.i_clk (i_clk),
		.bank  (u_bank.mem)
	);

	conv_engine #(.N_CH(N_CH)) u_conv_engine (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.seq         (u_seq.conv),
		.bank        (u_bank.rd),
		.o_res_valid (res_valid),
		.o_res       (res)
	);

	pixel_output u_pixel_output (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.seq         (u_seq.out),
		.bank        (u_bank.rd),
		.i_res_valid (res_valid),
		.i_res       (res),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data)
	);

endmodule

`default_nettype wire

// File: image_core_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module image_core_asserts (
	input logic       i_clk,
	input logic       i_rst_n,
	input logic       i_op_ready,
	input logic       i_in_ready,
	input logic       i_out_valid,
	input logic [2:0] i_phase
);
	int fail_cnt = 0;  // failed assertions so far

	a_ready_vs_beat: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(i_op_ready && i_out_valid))
		else begin
			fail_cnt++;
			$error("o_op_ready and o_out_valid high in the same cycle");
		end

	// in_ready may drop before the phase leaves load
	a_in_ready_load: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_in_ready |-> (i_phase == image_pkg::PH_LOAD))
		else begin
			fail_cnt++;
			$error("o_in_ready high outside the load phase");
		end

	a_reset_quiet: assert property (@(posedge i_clk) !i_rst_n |-> !i_op_ready)
		else begin
			fail_cnt++;
			$error("o_op_ready high during reset");
		end

endmodule

`default_nettype wire

// File: tb_image_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_image_core;
	localparam int N_CH       = 32;
	localparam int N_BYTES    = N_CH * 64;
	localparam int CLK_PERIOD = 100;
	localparam int SEED       = 32'h80a;
	// load with gaps plus a bounded number of ops of at most OP_CYC cycles each
	localparam int LOAD_CYC   = 4 * N_BYTES;
	localparam int OP_CYC     = 4 * N_CH + 20;
	localparam int N_OPS      = 160;
	localparam int WATCH_CYC  = 10 + LOAD_CYC + N_OPS * OP_CYC + 1000;

	logic       i_clk;
	logic       i_rst_n;
	logic       i_op_valid;
	logic [3:0] i_op_mode;
	logic       o_op_ready;
	logic       i_in_valid;
	logic [7:0] i_in_data;
	logic       o_in_ready;
	logic       o_out_valid;
	logic [13:0] o_out_data;

	logic [7:0] img [N_CH][8][8];  // reference image
	int org_r;
	int org_c;
	int depth;
	int exp_q [$];
	int test_cnt;
	int check_cnt;
	int err_cnt;
	int err_mark;

	image_core #(.N_CH(N_CH)) u_image_core (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_op_valid  (i_op_valid),
		.i_op_mode   (i_op_mode),
		.o_op_ready  (o_op_ready),
		.i_in_valid  (i_in_valid),
		.i_in_data   (i_in_data),
		.o_in_ready  (o_in_ready),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data)
	);

	bind image_core image_core_asserts u_image_core_asserts (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_op_ready  (o_op_ready),
		.i_in_ready  (o_in_ready),
		.i_out_valid (o_out_valid),
		.i_phase     (u_seq.phase)
	);

	always #(CLK_PERIOD / 2) i_clk = ~i_clk;

	task automatic compare_value(input string name, input int act, input int exp);
		check_cnt++;
		assert (act == exp) else begin
			$display("Error at %0t ns: %s expected %0d, actual %0d", $time, name, exp, act);
			err_cnt++;
		end
	endtask

	task automatic require(input bit cond, input string what);
		check_cnt++;
		assert (cond) else begin
			$display("at %0t ns: %s", $time, what);
			err_cnt++;
		end
	endtask

	function automatic int pix(input int ch, input int r, input int c);
		if (r < 0 || r > 7 || c < 0 || c > 7)
			return 0;  // zero padding
		return int'(img[ch][r][c]);
	endfunction

	task automatic display_beats();
		for (int ch = 0; ch < depth; ch++)
			for (int s = 0; s < 4; s++)
				exp_q.push_back(pix(ch, org_r + s / 2, org_c + s % 2));
	endtask

	task automatic conv_beats();
		int sum;
		for (int o = 0; o < 4; o++) begin
			sum = 0;
			for (int ch = 0; ch < depth; ch++)
				for (int dr = -1; dr <= 1; dr++)
					for (int dc = -1; dc <= 1; dc++)
						sum += (dr == 0 ? 2 : 1) * (dc == 0 ? 2 : 1) *
							pix(ch, org_r + o / 2 + dr, org_c + o % 2 + dc);
			exp_q.push_back((sum + 8) / 16);  // half up
		end
	endtask

	task automatic update_view(input image_pkg::op_e op);
		case (op)
			image_pkg::OP_RIGHT:      if (org_c < 6) org_c++;
			image_pkg::OP_LEFT:       if (org_c > 0) org_c--;
			image_pkg::OP_DOWN:       if (org_r < 6) org_r++;
			image_pkg::OP_UP:         if (org_r > 0) org_r--;
			image_pkg::OP_DEPTH_DOWN: if (depth > N_CH / 4) depth = depth / 2;
			image_pkg::OP_DEPTH_UP:   if (depth < N_CH) depth = depth * 2;
			default: ;
		endcase
	endtask

	// called right after the edge where o_op_ready was seen
	task automatic send_op(input image_pkg::op_e op);
		i_op_valid <= 1'b1;
		i_op_mode  <= op;
		@(posedge i_clk);
		i_op_valid <= 1'b0;
	endtask

	task automatic feed_image();
		int k;
		k = 0;
		while (k < N_BYTES) begin
			@(posedge i_clk);
			if (i_in_valid && o_in_ready)
				k++;
			if (k < N_BYTES) begin
				i_in_valid <= ($urandom % 4) != 0;  // random gaps
				i_in_data  <= img[k / 64][(k / 8) % 8][k % 8];
			end else begin
				i_in_valid <= 1'b0;
			end
		end
	endtask

	task automatic collect_beats(input int limit);
		int n;
		int cyc;
		int first;
		int last;
		bit seen;
		n = 0;
		cyc = 0;
		first = 0;
		last = 0;
		seen = 1'b0;
		while (!seen && cyc < limit) begin
			@(posedge i_clk);
			cyc++;
			if (o_out_valid) begin
				if (n == 0)
					first = cyc;
				last = cyc;
				if (n < exp_q.size())
					compare_value("o_out_data", int'(o_out_data), exp_q[n]);
				n++;
			end
			seen = o_op_ready;
		end
		require(seen, "o_op_ready did not pulse in time");
		compare_value("o_out_valid beat count", n, exp_q.size());
		if (n > 0)
			require(last - first + 1 == n, "output beats not in consecutive cycles");
	endtask

	task automatic run_op(input image_pkg::op_e op);
		exp_q.delete();
		if (op == image_pkg::OP_DISPLAY)
			display_beats();
		else if (op == image_pkg::OP_CONV)
			conv_beats();
		send_op(op);
		if (op == image_pkg::OP_LOAD)
			feed_image();
		collect_beats(op inside {image_pkg::OP_DISPLAY, image_pkg::OP_CONV} ? 4 * depth + 12 : 4);
		update_view(op);
	endtask

	task automatic move_origin(input int r, input int c);
		while (org_r < r) run_op(image_pkg::OP_DOWN);
		while (org_r > r) run_op(image_pkg::OP_UP);
		while (org_c < c) run_op(image_pkg::OP_RIGHT);
		while (org_c > c) run_op(image_pkg::OP_LEFT);
	endtask

	task automatic close_test(input string name);
		test_cnt++;
		$display("test %0d (%s) done, %0d errors", test_cnt, name, err_cnt - err_mark);
		err_mark = err_cnt;
	endtask

	initial begin
		#(WATCH_CYC * CLK_PERIOD);
		$display("timeout after %0d cycles, DUT stopped responding", WATCH_CYC);
		$display("Checks failed");
		$finish;
	end

	initial begin
		i_clk      = 1'b0;
		i_rst_n    = 1'b0;
		i_op_valid = 1'b0;
		i_op_mode  = '0;
		i_in_valid = 1'b0;
		i_in_data  = '0;
		org_r      = 0;
		org_c      = 0;
		depth      = N_CH;
		test_cnt   = 0;
		check_cnt  = 0;
		err_cnt    = 0;
		err_mark   = 0;
		void'($urandom(SEED));
		for (int k = 0; k < N_BYTES; k++)
			img[k / 64][(k / 8) % 8][k % 8] = 8'($urandom);

		repeat (3) @(posedge i_clk);
		require(!o_op_ready && !o_in_ready && !o_out_valid, "outputs active during reset");
		i_rst_n <= 1'b1;
		exp_q.delete();
		collect_beats(2);
		run_op(image_pkg::OP_LOAD);
		close_test("reset and load");

		run_op(image_pkg::OP_DISPLAY);
		close_test("display at origin");

		run_op(image_pkg::OP_LEFT);  // already at column 0
		run_op(image_pkg::OP_UP);
		run_op(image_pkg::OP_DISPLAY);
		repeat (7) run_op(image_pkg::OP_RIGHT);
		repeat (7) run_op(image_pkg::OP_DOWN);
		run_op(image_pkg::OP_DISPLAY);
		move_origin(3, 2);
		run_op(image_pkg::OP_DISPLAY);
		close_test("origin shifts");

		repeat (2) run_op(image_pkg::OP_DEPTH_DOWN);
		run_op(image_pkg::OP_DISPLAY);
		run_op(image_pkg::OP_DEPTH_DOWN);  // stays at the minimum
		run_op(image_pkg::OP_DISPLAY);
		run_op(image_pkg::OP_DEPTH_UP);
		run_op(image_pkg::OP_DISPLAY);
		run_op(image_pkg::OP_DEPTH_UP);
		run_op(image_pkg::OP_DISPLAY);
		close_test("depth scaling");

		for (int d = 0; d < 3; d++) begin
			move_origin(3, 2);
			run_op(image_pkg::OP_CONV);
			move_origin(0, 0);
			run_op(image_pkg::OP_CONV);
			move_origin(6, 6);
			run_op(image_pkg::OP_CONV);
			run_op(image_pkg::OP_DEPTH_DOWN);
		end
		close_test("gaussian conv");

		run_op(image_pkg::OP_MEDIAN);
		run_op(image_pkg::OP_HAAR);
		close_test("dropped ops");

		err_cnt += u_image_core.u_image_core_asserts.fail_cnt;  // protocol assertions
		$display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: image_core.f
image_pkg.sv
seq_if.sv
bank_if.sv
op_sequencer.sv
bank_addr_gen.sv
image_bank.sv
conv_engine.sv
pixel_output.sv
image_core.sv
image_core_asserts.sv
tb_image_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_image_core
FLIST     ?= image_core.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Checks failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for failures"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	@./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
